/* hdl/histPkg.sv */
package histPkg;

    // time-bin address, 16 bins per pixel histogram
    localparam int BIN_WIDTH = 4;
    localparam int BIN_NUM = 16;

    // small pixel array
    localparam int PIXEL_WIDTH = 2;
    localparam int PIXEL_NUM = 4;

    // samples per pixel per acquisition, acquisitions per frame
    localparam int DATA_NUM = 3;
    localparam int ACQ_NUM = 4;
    localparam int SAMPLE_WIDTH = $clog2(DATA_NUM);
    localparam int ACQ_WIDTH = $clog2(ACQ_NUM);

    // 48 writes per frame, so 8 bits never wrap
    localparam int COUNT_WIDTH = 8;

    // flat memory, pixel above bin
    localparam int ADDR_WIDTH = PIXEL_WIDTH + BIN_WIDTH;
    localparam int BIN_TOTAL = PIXEL_NUM * BIN_NUM;

    // sequencer states
    localparam logic [1:0] ST_RUN = 2'd0;
    localparam logic [1:0] ST_PUBLISH = 2'd1;
    localparam logic [1:0] ST_CLEAR = 2'd2;

    // one memory address, seen flat by the sweep
    // or split into pixel and bin by a write
    typedef union packed {
        logic [ADDR_WIDTH-1:0] flat;
        struct packed {
            logic [PIXEL_WIDTH-1:0] pixel;
            logic [BIN_WIDTH-1:0] bin;
        } field;
    } histAddr_u;

endpackage

/* hdl/frameCounter.sv */
`timescale 1ns/1ps

module frameCounter (
    input  logic                            clk,
    input  logic                            combin_res,
    input  logic                            accept,
    input  logic                            publish,
    input  logic                            clearing,
    output logic [histPkg::PIXEL_WIDTH-1:0] pixel,
    output logic                            frameLast,
    output histPkg::histAddr_u              clearIdx,
    output logic                            clearLast
);
    import histPkg::*;

    // nested position inside the frame
    logic [SAMPLE_WIDTH-1:0] sampleCnt;
    logic [ACQ_WIDTH-1:0]    acqCnt;
    logic                    sampleLast;
    logic                    pixelLast;
    logic                    acqLast;
    logic                    sweepStep;

    // wrap points of each level
    assign sampleLast = (sampleCnt == SAMPLE_WIDTH'(DATA_NUM - 1));
    assign pixelLast  = (pixel == PIXEL_WIDTH'(PIXEL_NUM - 1));
    assign acqLast    = (acqCnt == ACQ_WIDTH'(ACQ_NUM - 1));

    // next accepted write closes the frame
    assign frameLast = sampleLast && pixelLast && acqLast;

    // sweep only moves in the clear state, publish cycle holds index 0
    assign sweepStep = clearing && !publish;
    assign clearLast = sweepStep && (clearIdx.flat == ADDR_WIDTH'(BIN_TOTAL - 1));

    // sample -> pixel -> acquisition, all wrap together at frame end
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixel     <= '0;
            acqCnt    <= '0;
        end else if (accept) begin
            if (!sampleLast) begin
                sampleCnt <= sampleCnt + SAMPLE_WIDTH'(1);
            end else begin
                sampleCnt <= '0;
                if (!pixelLast) begin
                    pixel <= pixel + PIXEL_WIDTH'(1);
                end else begin
                    pixel <= '0;
                    // last pixel done, next acquisition
                    if (!acqLast) begin
                        acqCnt <= acqCnt + ACQ_WIDTH'(1);
                    end else begin
                        acqCnt <= '0;
                    end
                end
            end
        end
    end

    // flat sweep index
    // wraps 63 -> 0 on the last clear cycle, ready for the next frame
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            clearIdx <= '0;
        end else if (sweepStep) begin
            clearIdx.flat <= clearIdx.flat + ADDR_WIDTH'(1);
        end
    end

endmodule

/* hdl/frameSequencer.sv */
`timescale 1ns/1ps

module frameSequencer (
    input  logic clk,
    input  logic combin_res,
    input  logic wrEn,
    input  logic frameLast,
    input  logic clearLast,
    output logic accept,
    output logic publish,
    output logic clearing
);
    import histPkg::*;

    logic [1:0] state;
    logic [1:0] nextState;

    // strobes only count while accumulating
    assign accept = wrEn && (state == ST_RUN);

    // one cycle for peak hand-off
    assign publish = (state == ST_PUBLISH);

    // status level covers publish and the whole sweep
    assign clearing = (state != ST_RUN);

    always_comb begin
        nextState = state;
        case (state)
            ST_RUN: begin
                // last write of the frame
                if (accept && frameLast) begin
                    nextState = ST_PUBLISH;
                end
            end
            ST_PUBLISH: begin
                nextState = ST_CLEAR;
            end
            ST_CLEAR: begin
                // final memory entry zeroed this cycle
                if (clearLast) begin
                    nextState = ST_RUN;
                end
            end
            default: begin
                nextState = ST_RUN;
            end
        endcase
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state <= ST_RUN;
        end else begin
            state <= nextState;
        end
    end

endmodule

/* hdl/histMemory.sv */
`timescale 1ns/1ps

module histMemory (
    input  logic                            clk,
    input  logic                            combin_res,
    input  logic                            accept,
    input  logic                            clearing,
    input  logic [histPkg::PIXEL_WIDTH-1:0] pixel,
    input  logic [histPkg::BIN_WIDTH-1:0]   addr,
    input  histPkg::histAddr_u              clearIdx,
    output logic [histPkg::COUNT_WIDTH-1:0] newCount,
    output logic [histPkg::COUNT_WIDTH-1:0] binCount
);
    import histPkg::*;

    // one counter per pixel and bin
    logic [COUNT_WIDTH-1:0] mem [BIN_TOTAL];

    // write address, pixel field above bin field
    histAddr_u wrAddr;

    always_comb begin
        wrAddr.field.pixel = pixel;
        wrAddr.field.bin   = addr;
    end

    // read-modify-write value, also feeds the peak tracker
    assign newCount = mem[wrAddr.flat] + COUNT_WIDTH'(1);

    // histogram array
    // write on accept, otherwise zero one entry per clearing cycle
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int i = 0; i < BIN_TOTAL; i++) begin
                mem[i] <= '0;
            end
        end else if (accept) begin
            mem[wrAddr.flat] <= newCount;
        end else if (clearing) begin
            // accept is never high here, sequencer blocks it
            mem[clearIdx.flat] <= '0;
        end
    end

    // count of the bin just written
    // held until the next accepted write
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binCount <= '0;
        end else if (accept) begin
            binCount <= newCount;
        end
    end

endmodule

/* hdl/peakTracker.sv */
`timescale 1ns/1ps

module peakTracker (
    input  logic                                         clk,
    input  logic                                         combin_res,
    input  logic                                         accept,
    input  logic [histPkg::PIXEL_WIDTH-1:0]              pixel,
    input  logic [histPkg::BIN_WIDTH-1:0]                addr,
    input  logic [histPkg::COUNT_WIDTH-1:0]              newCount,
    input  logic                                         publish,
    output logic [histPkg::PIXEL_NUM*histPkg::BIN_WIDTH-1:0] peakBins,
    output logic                                         frameDone,
    output logic                                         hisNum
);
    import histPkg::*;

    // running maximum per pixel and the bin that holds it
    logic [COUNT_WIDTH-1:0] runMax [PIXEL_NUM];
    logic [BIN_WIDTH-1:0]   runBin [PIXEL_NUM];

    // strictly greater only, a tie keeps the bin that got there first
    logic newPeak;

    assign newPeak = accept && (newCount > runMax[pixel]);

    // running state, updated on the same edge as the memory write
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                runMax[p] <= '0;
                runBin[p] <= '0;
            end
        end else if (publish) begin
            // fresh start for the next frame
            for (int p = 0; p < PIXEL_NUM; p++) begin
                runMax[p] <= '0;
                runBin[p] <= '0;
            end
        end else if (newPeak) begin
            runMax[pixel] <= newCount;
            runBin[pixel] <= addr;
        end
    end

    // published peaks, pixel 0 in the low bits
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            peakBins <= '0;
        end else if (publish) begin
            for (int p = 0; p < PIXEL_NUM; p++) begin
                peakBins[p*BIN_WIDTH +: BIN_WIDTH] <= runBin[p];
            end
        end
    end

    // frame done pulse and histogram toggle land in the same cycle
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            frameDone <= 1'b0;
            hisNum    <= 1'b0;
        end else begin
            frameDone <= publish;
            if (publish) begin
                hisNum <= ~hisNum;
            end
        end
    end

endmodule

/* hdl/histogramBuilder.sv */
`timescale 1ns/1ps

module histogramBuilder (
    input  logic                                              clk,
    input  logic                                              combin_res,
    input  logic                                              wrEn,
    input  logic [histPkg::BIN_WIDTH-1:0]                     addr,
    output logic [histPkg::COUNT_WIDTH-1:0]                   binCount,
    output logic [histPkg::PIXEL_NUM*histPkg::BIN_WIDTH-1:0]  peakBins,
    output logic                                              frameDone,
    output logic                                              hisNum,
    output logic                                              clearing
);
    import histPkg::*;

    // sequencer controls
    logic accept;
    logic publish;

    // position in frame and sweep
    logic [PIXEL_WIDTH-1:0] pixel;
    logic                   frameLast;
    histAddr_u              clearIdx;
    logic                   clearLast;

    // incremented count of the addressed bin
    logic [COUNT_WIDTH-1:0] newCount;

    // run / publish / clear
    frameSequencer i_frameSequencer (
        .clk        (clk),
        .combin_res (combin_res),
        .wrEn       (wrEn),
        .frameLast  (frameLast),
        .clearLast  (clearLast),
        .accept     (accept),
        .publish    (publish),
        .clearing   (clearing)
    );

    // sample, pixel, acquisition and sweep counters
    frameCounter i_frameCounter (
        .clk        (clk),
        .combin_res (combin_res),
        .accept     (accept),
        .publish    (publish),
        .clearing   (clearing),
        .pixel      (pixel),
        .frameLast  (frameLast),
        .clearIdx   (clearIdx),
        .clearLast  (clearLast)
    );

    histMemory i_histMemory (
        .clk        (clk),
        .combin_res (combin_res),
        .accept     (accept),
        .clearing   (clearing),
        .pixel      (pixel),
        .addr       (addr),
        .clearIdx   (clearIdx),
        .newCount   (newCount),
        .binCount   (binCount)
    );

    // per-pixel peak search
    peakTracker i_peakTracker (
        .clk        (clk),
        .combin_res (combin_res),
        .accept     (accept),
        .pixel      (pixel),
        .addr       (addr),
        .newCount   (newCount),
        .publish    (publish),
        .peakBins   (peakBins),
        .frameDone  (frameDone),
        .hisNum     (hisNum)
    );

endmodule

/* verification/histogramBuilder_assertions.sv */
`timescale 1ns/1ps

module histogramBuilder_assertions (
    input logic clk,
    input logic combin_res,
    input logic frameDone,
    input logic hisNum,
    input logic clearing
);
    import histPkg::*;

    // length of the current clearing run
    int clearRun;
    // failure tally
    int assertFails = 0;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            clearRun <= 0;
        end else if (clearing) begin
            clearRun <= clearRun + 1;
        end else begin
            clearRun <= 0;
        end
    end

    // single-cycle done pulse
    donePulse: assert property (@(posedge clk) disable iff (!combin_res)
        frameDone |=> !frameDone)
        else begin $error("frameDone high for more than one cycle"); assertFails++; end

    // publish cycle plus one sweep of the memory
    clearFull: assert property (@(posedge clk) disable iff (!combin_res)
        $fell(clearing) |-> clearRun == 1 + BIN_TOTAL)
        else begin $error("clearing window ended early"); assertFails++; end

    clearBound: assert property (@(posedge clk) disable iff (!combin_res)
        clearing |-> clearRun < 1 + BIN_TOTAL)
        else begin $error("clearing window too long"); assertFails++; end

    // toggle only together with done
    hisToggle: assert property (@(posedge clk) disable iff (!combin_res)
        $changed(hisNum) |-> frameDone)
        else begin $error("hisNum changed without frameDone"); assertFails++; end

    // done lands one cycle into the clear window
    doneAfterClear: assert property (@(posedge clk) disable iff (!combin_res)
        $rose(clearing) |=> $rose(frameDone))
        else begin $error("frameDone not one cycle after clearing rose"); assertFails++; end

endmodule

bind histogramBuilder histogramBuilder_assertions i_assertions (
    .clk        (clk),
    .combin_res (combin_res),
    .frameDone  (frameDone),
    .hisNum     (hisNum),
    .clearing   (clearing)
);

/* verification/histogramBuilder_tb.sv */
`timescale 1ns/1ps

module histogramBuilder_tb;
    import histPkg::*;

    localparam int HALF_PERIOD = 4;
    localparam int FRAME_NUM = 3;
    localparam int FRAME_WRITES = DATA_NUM * PIXEL_NUM * ACQ_NUM;
    localparam int FRAME_WORDS = FRAME_WRITES + PIXEL_NUM;
    localparam int CLEAR_CYCLES = 1 + BIN_TOTAL;
    localparam int WAIT_LIMIT = 200;
    localparam logic [31:0] LFSR_SEED = 32'ha52c0ae4;

    logic                           clk;
    logic                           combin_res;
    logic                           wrEn;
    logic [BIN_WIDTH-1:0]           addr;
    logic [COUNT_WIDTH-1:0]         binCount;
    logic [PIXEL_NUM*BIN_WIDTH-1:0] peakBins;
    logic                           frameDone;
    logic                           hisNum;
    logic                           clearing;

    // 48 bin addresses then 4 expected peaks, per frame
    logic [BIN_WIDTH-1:0] vecMem [FRAME_NUM*FRAME_WORDS];

    // reference histograms, plus write index where each count was reached
    int modelCount [PIXEL_NUM][BIN_NUM];
    int modelReach [PIXEL_NUM][BIN_NUM];

    logic [31:0] lfsrState;
    logic        expHis;
    int          mismatchCount;
    int          timeoutCount;
    int          setupCount;
    int          fd;

    histogramBuilder i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit
    task automatic takeBits(input int n, output int value);
        value = 0;
        for (int k = 0; k < n; k++) begin
            lfsrState = lfsrNext(lfsrState);
            value = (value << 1) | int'(lfsrState[0]);
        end
    endtask

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            mismatchCount++;
            $display("Fail at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    // highest count, tie goes to the bin that got there first
    function automatic logic [PIXEL_NUM*BIN_WIDTH-1:0] modelPeaks();
        logic [PIXEL_NUM*BIN_WIDTH-1:0] peaks;
        int best;
        peaks = '0;
        for (int p = 0; p < PIXEL_NUM; p++) begin
            best = 0;
            for (int b = 1; b < BIN_NUM; b++) begin
                if (modelCount[p][b] > modelCount[p][best] ||
                    (modelCount[p][b] == modelCount[p][best] && modelCount[p][b] > 0 &&
                     modelReach[p][b] < modelReach[p][best])) begin
                    best = b;
                end
            end
            peaks[p*BIN_WIDTH +: BIN_WIDTH] = BIN_WIDTH'(best);
        end
        return peaks;
    endfunction

    task automatic runFrame(input int f);
        int                             base;
        int                             pix;
        int                             gap;
        int                             fire;
        int                             junk;
        int                             held;
        int                             spin;
        int                             highCycles;
        logic                           clearNow;
        logic                           doneSeen;
        logic [BIN_WIDTH-1:0]           bin;
        logic [PIXEL_NUM*BIN_WIDTH-1:0] filePeaks;
        base = f * FRAME_WORDS;
        // histograms start empty each frame
        foreach (modelCount[p, b]) begin
            modelCount[p][b] = 0;
            modelReach[p][b] = 0;
        end
        @(posedge clk);
        wrEn <= 1'b1;
        addr <= vecMem[base];
        for (int i = 0; i < FRAME_WRITES; i++) begin
            // write i taken at this edge
            @(posedge clk);
            bin = vecMem[base + i];
            pix = (i / DATA_NUM) % PIXEL_NUM;
            modelCount[pix][bin]++;
            modelReach[pix][bin] = i;
            takeBits(2, gap);
            if (i < FRAME_WRITES - 1 && gap == 0) begin
                addr <= vecMem[base + i + 1];
            end else begin
                wrEn <= 1'b0;
            end
            @(negedge clk);
            checkValue(32'(binCount), modelCount[pix][bin], "binCount");
            // clear window opens right after the last write
            checkValue(32'(clearing), (i == FRAME_WRITES - 1) ? 1 : 0, "clearing");
            if (i < FRAME_WRITES - 1 && gap != 0) begin
                repeat (gap) @(posedge clk);
                wrEn <= 1'b1;
                addr <= vecMem[base + i + 1];
            end
        end
        foreach (filePeaks[k]) begin
            filePeaks[k] = vecMem[base + FRAME_WRITES + k / BIN_WIDTH][k % BIN_WIDTH];
        end
        held = modelCount[pix][bin];
        takeBits(1, fire);
        highCycles = 0;
        doneSeen = 1'b0;
        spin = 0;
        // walk the clear window, frameDone expected in its 2nd cycle
        while ((clearing === 1'b1 || !doneSeen) && spin < WAIT_LIMIT) begin
            clearNow = clearing;
            if (clearNow === 1'b1) begin
                highCycles++;
            end
            if (frameDone === 1'b1) begin
                doneSeen = 1'b1;
                expHis = ~expHis;
                checkValue(highCycles, 2, "frameDone cycle in clear window");
                checkValue(32'(hisNum), 32'(expHis), "hisNum");
                checkValue(32'(peakBins), 32'(filePeaks), "peakBins vs vector file");
                checkValue(32'(peakBins), 32'(modelPeaks()), "peakBins vs model");
            end
            checkValue(32'(binCount), held, "binCount in clear window");
            @(posedge clk);
            // junk strobes, stopped before the window closes
            if (fire != 0 && clearNow === 1'b1 && highCycles < CLEAR_CYCLES - 1) begin
                takeBits(1, junk);
                wrEn <= junk[0];
                takeBits(BIN_WIDTH, junk);
                addr <= junk[BIN_WIDTH-1:0];
            end else begin
                wrEn <= 1'b0;
            end
            @(negedge clk);
            spin++;
        end
        if (spin >= WAIT_LIMIT) begin
            timeoutCount++;
            $display("timeout: frame %0d never finished its clear window", f);
        end
        checkValue(highCycles, CLEAR_CYCLES, "clearing length");
    endtask

    initial begin
        combin_res = 1'b0;
        wrEn = 1'b0;
        addr = '0;
        lfsrState = LFSR_SEED;
        expHis = 1'b0;
        mismatchCount = 0;
        timeoutCount = 0;
        setupCount = 0;
        fd = $fopen("verification/histVectors.txt", "r");
        if (fd == 0) begin
            setupCount++;
            $display("vector file verification/histVectors.txt could not be opened");
        end else begin
            $fclose(fd);
            $readmemh("verification/histVectors.txt", vecMem);
        end
        repeat (5) @(posedge clk);
        combin_res <= 1'b1;
        @(negedge clk);
        // idle outputs after reset
        checkValue(32'(frameDone), 0, "frameDone after reset");
        checkValue(32'(clearing), 0, "clearing after reset");
        checkValue(32'(hisNum), 0, "hisNum after reset");
        checkValue(32'(binCount), 0, "binCount after reset");
        checkValue(32'(peakBins), 0, "peakBins after reset");
        for (int f = 0; f < FRAME_NUM; f++) begin
            if (timeoutCount == 0 && setupCount == 0) begin
                runFrame(f);
            end
        end
        $display("errors: %0d mismatches, %0d timeouts, %0d setup, %0d assertion failures",
                 mismatchCount, timeoutCount, setupCount, i_dut.i_assertions.assertFails);
        if (mismatchCount == 0 && timeoutCount == 0 && setupCount == 0 &&
            i_dut.i_assertions.assertFails == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* verification/histVectors.txt */
// data lines hold one acquisition each: 3 bin addresses for each of pixels 0 to 3
// the line after four data lines holds the expected peak bins of pixels 0 to 3
// frame 1
3 3 5 a a a f e d 8 9 8
5 3 7 b b b f f e 9 4 4
7 7 1 b 0 0 d d d 4 9 8
2 3 7 a 0 c d 0 f 8 1 1
// expected peaks of frame 1
3 b d 8
// frame 2
0 1 2 4 4 4 c d c 2 2 6
3 4 5 4 4 4 d e e 6 6 2
6 7 8 4 4 4 e d c 1 1 1
9 a b 4 4 4 f f f 1 2 6
// expected peaks of frame 2
0 4 e 1
// frame 3
f f 0 4 7 7 1 2 3 e e e
0 0 f 9 9 9 3 2 1 b b b
5 5 5 4 4 7 2 2 a b e 3
5 0 f 4 9 7 a a a 3 3 3
// expected peaks of frame 3
5 4 2 b

/* sim.f */
hdl/histPkg.sv
hdl/frameCounter.sv
hdl/frameSequencer.sv
hdl/histMemory.sv
hdl/peakTracker.sv
hdl/histogramBuilder.sv
verification/histogramBuilder_assertions.sv
verification/histogramBuilder_tb.sv

/* Makefile */
# Verilator flow for the histogram builder testbench

VERILATOR ?= verilator
TOP       ?= histogramBuilder_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= TEST RESULT: PASS

SOURCES := $(wildcard hdl/*.sv verification/*.sv)
SIM_EXE := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_EXE)

$(SIM_EXE): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_EXE)
	./$(SIM_EXE) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
